/* source/exPkg.sv */
// Execute backend shared types
package exPkg;

	// Micro-op codes seen by EX1 and EX2
	typedef enum logic [3:0] {
		opNop    = 4'd0,	// Bubble, no effect
		opMovImm = 4'd1,	// Rn = imm
		opAdd    = 4'd2,	// Rn = Rs + Rt
		opSub    = 4'd3,	// Rn = Rs - Rt
		opAnd    = 4'd4,	// Rn = Rs & Rt
		opOr     = 4'd5,	// Rn = Rs | Rt
		opXor    = 4'd6,	// Rn = Rs ^ Rt
		opCmpEq  = 4'd7,	// T = (Rs == Rt)
		opCmpGt  = 4'd8,	// T = (Rs > Rt), signed
		opMul    = 4'd9,	// Rn = low word of Rs * Rt
		opSleep  = 4'd10	// Stall only, nothing written
	} opCode;

	// Hardwired zero register, reads zero and drops writes
	localparam logic [3:0] zeroReg = 4'd0;

	// EX2 hold lengths in cycles
	localparam int mulHoldCycles = 3;	// Covers the two multiplier stages
	localparam int sleepHoldCycles = 15;	// Also the hold counter ceiling

endpackage

/* source/regFile.sv */
// General register file
`timescale 1ns/1ps

module regFile import exPkg::*; #(
	parameter int dataWidth = 32,
	parameter int regCount = 16,
	localparam int idWidth = $clog2(regCount)
) (
	input  logic clock,
	input  logic rstN,
	input  logic [idWidth-1:0] readIdA,	// Source A id
	input  logic [idWidth-1:0] readIdB,	// Source B id
	output logic [dataWidth-1:0] readValA,
	output logic [dataWidth-1:0] readValB,
	input  logic writeEnable,
	input  logic [idWidth-1:0] writeId,
	input  logic [dataWidth-1:0] writeValue
);

	logic [dataWidth-1:0] regs [regCount];	// Storage array

	// Async reads, zero register masked
	assign readValA = (readIdA == zeroReg) ? '0 : regs[readIdA];
	assign readValB = (readIdB == zeroReg) ? '0 : regs[readIdB];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;	// All registers start at zero
			end
		end else if (writeEnable && (writeId != zeroReg)) begin
			regs[writeId] <= writeValue;	// Writes to R0 fall away
		end
	end

endmodule

/* source/aluUnit.sv */
// Integer ALU with compare flag
`timescale 1ns/1ps

module aluUnit import exPkg::*; #(
	parameter int dataWidth = 32
) (
	input  opCode cmd,
	input  logic [dataWidth-1:0] valA,	// Forwarded Rs
	input  logic [dataWidth-1:0] valB,	// Forwarded Rt
	input  logic [dataWidth-1:0] valImm,	// Decoded immediate
	output logic [dataWidth-1:0] result,
	output logic resultT	// Compare outcome for SR.T
);

	always_comb begin
		result = '0;	// Unhandled codes give zero
		resultT = 1'b0;

		case (cmd)
			opMovImm: begin
				result = valImm;
			end
			opAdd: begin
				result = valA + valB;
			end
			opSub: begin
				result = valA - valB;
			end
			opAnd: begin
				result = valA & valB;
			end
			opOr: begin
				result = valA | valB;
			end
			opXor: begin
				result = valA ^ valB;
			end
			opCmpEq: begin
				resultT = (valA == valB);	// Result stays zero
			end
			opCmpGt: begin
				resultT = ($signed(valA) > $signed(valB));	// Signed compare
			end
			default: begin
				// Mul, sleep and nop produce nothing here
			end
		endcase
	end

endmodule

/* source/mulUnit.sv */
// Two-stage integer multiplier
`timescale 1ns/1ps

module mulUnit #(
	parameter int dataWidth = 32
) (
	input  logic clock,
	input  logic rstN,
	input  logic [dataWidth-1:0] mulA,	// Frozen EX1 operand A
	input  logic [dataWidth-1:0] mulB,	// Frozen EX1 operand B
	output logic [dataWidth-1:0] mulRes	// Low word, two edges after inputs
);

	logic [dataWidth-1:0] regA;	// Stage 1 operand latch
	logic [dataWidth-1:0] regB;
	logic [2*dataWidth-1:0] fullProd;	// Full-width product

	assign fullProd = regA * regB;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			regA <= '0;
			regB <= '0;
			mulRes <= '0;
		end else begin
			regA <= mulA;	// Stage 1
			regB <= mulB;
			mulRes <= fullProd[dataWidth-1:0];	// Stage 2, low half only
		end
	end

endmodule

/* source/exStage1.sv */
// EX1 operand fetch and ALU stage
`timescale 1ns/1ps

module exStage1 import exPkg::*; #(
	parameter int dataWidth = 32,
	parameter int regCount = 16,
	localparam int idWidth = $clog2(regCount)
) (
	input  logic clock,
	input  logic rstN,
	input  logic opValid,	// Incoming op strobe
	input  opCode opCmd,
	input  logic [idWidth-1:0] regIdRs,
	input  logic [idWidth-1:0] regIdRt,
	input  logic [idWidth-1:0] regIdRn,
	input  logic [dataWidth-1:0] regValImm,
	input  logic exHold,	// Stall from EX2
	input  logic wbValid,	// EX2 writeback, forwarding source
	input  logic [idWidth-1:0] wbId,
	input  logic [dataWidth-1:0] wbValue,
	output logic [idWidth-1:0] readIdA,
	output logic [idWidth-1:0] readIdB,
	input  logic [dataWidth-1:0] readValA,
	input  logic [dataWidth-1:0] readValB,
	output logic [dataWidth-1:0] mulA,	// To multiplier
	output logic [dataWidth-1:0] mulB,
	output logic ex1Valid,
	output opCode ex1Cmd,
	output logic [idWidth-1:0] ex1IdRn,
	output logic [dataWidth-1:0] ex1ValAlu,
	output logic ex1AluT
);

	logic [idWidth-1:0] idRs;	// Latched source ids
	logic [idWidth-1:0] idRt;
	logic [dataWidth-1:0] valImm;	// Latched immediate
	logic [dataWidth-1:0] valA;	// Forwarded operands
	logic [dataWidth-1:0] valB;
	logic [dataWidth-1:0] frozenA;	// Operands of the op now in EX2
	logic [dataWidth-1:0] frozenB;

	// Control registers, bubble on no strobe
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			ex1Valid <= 1'b0;
			ex1Cmd <= opNop;
		end else if (!exHold) begin
			ex1Valid <= opValid;
			ex1Cmd <= opValid ? opCmd : opNop;
		end
	end

	// Payload registers
	always_ff @(posedge clock) begin
		if (!exHold) begin
			idRs <= regIdRs;
			idRt <= regIdRt;
			ex1IdRn <= regIdRn;
			valImm <= regValImm;
			frozenA <= valA;	// Captured as the op moves to EX2
			frozenB <= valB;
		end
	end

	assign readIdA = idRs;
	assign readIdB = idRt;

	/* The op one ahead sits in EX2 and is visible on the
	   writeback bus, older ones are already in the file */
	assign valA = (wbValid && (wbId == idRs) && (idRs != zeroReg)) ? wbValue : readValA;
	assign valB = (wbValid && (wbId == idRt) && (idRt != zeroReg)) ? wbValue : readValB;

	// Stable through an EX2 hold
	assign mulA = frozenA;
	assign mulB = frozenB;

	aluUnit #(
		.dataWidth(dataWidth)
	) alu (
		.cmd(ex1Cmd),
		.valA(valA),
		.valB(valB),
		.valImm(valImm),
		.result(ex1ValAlu),
		.resultT(ex1AluT)
	);

endmodule

/* source/exStage2.sv */
// EX2 completion and writeback stage
`timescale 1ns/1ps

module exStage2 import exPkg::*; #(
	parameter int dataWidth = 32,
	parameter int regCount = 16,
	localparam int idWidth = $clog2(regCount)
) (
	input  logic clock,
	input  logic rstN,
	input  logic flush,	// Squash the op in EX2
	input  logic ex1Valid,
	input  opCode ex1Cmd,
	input  logic [idWidth-1:0] ex1IdRn,
	input  logic [dataWidth-1:0] ex1ValAlu,
	input  logic ex1AluT,
	input  logic [dataWidth-1:0] mulRes,
	output logic exHold,	// Stalls EX1 and the source
	output logic wbValid,
	output logic [idWidth-1:0] wbId,
	output logic [dataWidth-1:0] wbValue,
	output logic srT	// SR.T view
);

	localparam int holdWidth = $clog2(sleepHoldCycles + 1);

	logic ex2Valid;
	opCode ex2Cmd;
	logic [idWidth-1:0] ex2IdRn;
	logic [dataWidth-1:0] ex2ValAlu;
	logic ex2AluT;
	logic [holdWidth-1:0] holdCount;	// Cycles held so far
	logic [holdWidth-1:0] needHold;	// Cycles this op needs
	logic writesReg;
	logic isCompare;
	logic srTReg;	// Committed T bit

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			ex2Valid <= 1'b0;
			ex2Cmd <= opNop;
		end else if (!exHold) begin
			ex2Valid <= ex1Valid;
			ex2Cmd <= ex1Cmd;
		end
	end

	always_ff @(posedge clock) begin
		if (!exHold) begin
			ex2IdRn <= ex1IdRn;
			ex2ValAlu <= ex1ValAlu;
			ex2AluT <= ex1AluT;
		end
	end

	// Command decode
	always_comb begin
		needHold = '0;
		writesReg = 1'b0;
		isCompare = 1'b0;
		wbValue = ex2ValAlu;	// ALU by default

		case (ex2Cmd)
			opMovImm, opAdd, opSub, opAnd, opOr, opXor: begin
				writesReg = 1'b1;
			end
			opCmpEq, opCmpGt: begin
				isCompare = 1'b1;	// Flag only
			end
			opMul: begin
				needHold = holdWidth'(mulHoldCycles);
				writesReg = 1'b1;
				wbValue = mulRes;	// Settled by the last hold cycle
			end
			opSleep: begin
				needHold = holdWidth'(sleepHoldCycles);
			end
			default: begin
				// Nop does nothing
			end
		endcase

		if (!ex2Valid) begin
			needHold = '0;
			writesReg = 1'b0;
			isCompare = 1'b0;
		end
	end

	// Flush drops a pending hold at once
	assign exHold = (holdCount < needHold) && !flush;

	// Shown once the hold is done
	assign wbValid = writesReg && !exHold && !flush;
	assign wbId = ex2IdRn;

	// New flag visible in the compare's own cycle
	assign srT = (isCompare && !flush) ? ex2AluT : srTReg;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			srTReg <= 1'b0;
		end else if (isCompare && !flush) begin
			srTReg <= ex2AluT;
		end
	end

	// Hold counter, saturating
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			holdCount <= '0;
		end else if (exHold) begin
			holdCount <= holdCount + holdWidth'(holdCount != '1);
		end else begin
			holdCount <= '0;	// Ready for the next op
		end
	end

endmodule

/* source/exPipeline.sv */
// Two-stage execute backend top
`timescale 1ns/1ps

module exPipeline import exPkg::*; #(
	parameter int dataWidth = 32,
	parameter int regCount = 16,
	localparam int idWidth = $clog2(regCount)
) (
	input  logic clock,
	input  logic rstN,
	input  logic opValid,
	input  opCode opCmd,
	input  logic [idWidth-1:0] regIdRs,
	input  logic [idWidth-1:0] regIdRt,
	input  logic [idWidth-1:0] regIdRn,
	input  logic [dataWidth-1:0] regValImm,
	input  logic flush,
	output logic busy,	// Source must hold its op
	output logic wbValid,
	output logic [idWidth-1:0] wbId,
	output logic [dataWidth-1:0] wbValue,
	output logic srT
);

	logic exHold;
	logic [idWidth-1:0] readIdA;
	logic [idWidth-1:0] readIdB;
	logic [dataWidth-1:0] readValA;
	logic [dataWidth-1:0] readValB;
	logic [dataWidth-1:0] mulA;
	logic [dataWidth-1:0] mulB;
	logic [dataWidth-1:0] mulRes;
	logic ex1Valid;	// EX1 to EX2
	opCode ex1Cmd;
	logic [idWidth-1:0] ex1IdRn;
	logic [dataWidth-1:0] ex1ValAlu;
	logic ex1AluT;

	assign busy = exHold;

	regFile #(.dataWidth(dataWidth), .regCount(regCount)) rf (
		.clock(clock), .rstN(rstN),
		.readIdA(readIdA), .readIdB(readIdB),
		.readValA(readValA), .readValB(readValB),
		.writeEnable(wbValid), .writeId(wbId), .writeValue(wbValue)
	);

	exStage1 #(.dataWidth(dataWidth), .regCount(regCount)) ex1 (
		.clock(clock), .rstN(rstN), .opValid(opValid), .opCmd(opCmd),
		.regIdRs(regIdRs), .regIdRt(regIdRt), .regIdRn(regIdRn), .regValImm(regValImm),
		.exHold(exHold), .wbValid(wbValid), .wbId(wbId), .wbValue(wbValue),
		.readIdA(readIdA), .readIdB(readIdB), .readValA(readValA), .readValB(readValB),
		.mulA(mulA), .mulB(mulB),
		.ex1Valid(ex1Valid), .ex1Cmd(ex1Cmd), .ex1IdRn(ex1IdRn),
		.ex1ValAlu(ex1ValAlu), .ex1AluT(ex1AluT)
	);

	mulUnit #(.dataWidth(dataWidth)) mul (
		.clock(clock), .rstN(rstN), .mulA(mulA), .mulB(mulB), .mulRes(mulRes)
	);

	exStage2 #(.dataWidth(dataWidth), .regCount(regCount)) ex2 (
		.clock(clock), .rstN(rstN), .flush(flush),
		.ex1Valid(ex1Valid), .ex1Cmd(ex1Cmd), .ex1IdRn(ex1IdRn),
		.ex1ValAlu(ex1ValAlu), .ex1AluT(ex1AluT), .mulRes(mulRes),
		.exHold(exHold), .wbValid(wbValid), .wbId(wbId), .wbValue(wbValue), .srT(srT)
	);

endmodule

/* tb/tbTasks.svh */
// Testbench helpers and directed tests

// Counts an error and shows both values
task automatic reportMismatch(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
	$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
	errorCount++;
endtask

// Result predicted from the op rules
function automatic logic [31:0] expectValue(input opCode cmd, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] imm);
	case (cmd)
		opMovImm: return imm;
		opAdd: return a + b;
		opSub: return a - b;
		opAnd: return a & b;
		opOr: return a | b;
		opXor: return a ^ b;
		opMul: return a * b;	// Low word only
		default: return '0;
	endcase
endfunction

task automatic clearOp();
	opValid = 1'b0;
	opCmd = opNop;
endtask

// Drives an op and returns just after the edge that takes it
task automatic issueOp(input opCode cmd, input logic [3:0] rs, input logic [3:0] rt,
		input logic [3:0] rn, input logic [31:0] imm);
	int waited;
	opValid = 1'b1;
	opCmd = cmd;
	regIdRs = rs;
	regIdRt = rt;
	regIdRn = rn;
	regValImm = imm;
	waited = 0;
	@(negedge clock);
	while (busy !== 1'b0 && waited < waitLimit) begin
		@(negedge clock);	// Source holds its op
		waited++;
	end
	if (busy !== 1'b0) begin
		$display("Timeout at %0t: busy never dropped to accept an op", $time);
		errorCount++;
	end
	@(posedge clock);
	#1;
endtask

// Writing op, model updated in program order
task automatic runOp(input opCode cmd, input logic [3:0] rs, input logic [3:0] rt,
		input logic [3:0] rn, input logic [31:0] imm);
	logic [31:0] expVal;
	expVal = expectValue(cmd, regModel[rs], regModel[rt], imm);
	expIdQ.push_back(rn);
	expValQ.push_back(expVal);
	if (rn != zeroReg) begin
		regModel[rn] = expVal;	// R0 stays zero
	end
	issueOp(cmd, rs, rt, rn, imm);
endtask

// Idles until every expected writeback was seen
task automatic drainWrites();
	int waited;
	clearOp();
	waited = 0;
	while (expIdQ.size() != 0 && waited < waitLimit) begin
		@(posedge clock);
		#1;
		waited++;
	end
	if (expIdQ.size() != 0) begin
		$display("Timeout at %0t: %0d writebacks never appeared", $time, expIdQ.size());
		errorCount++;
		expIdQ.delete();
		expValQ.delete();
	end
endtask

// Length of the next busy pulse
task automatic countBusy(input int expected);
	int cycles;
	int waited;
	logic dropped;
	clearOp();
	cycles = 0;
	waited = 0;
	dropped = 1'b0;
	while (!dropped && waited < waitLimit) begin
		@(negedge clock);
		waited++;
		if (busy === 1'b1) begin
			cycles++;
		end else if (cycles > 0) begin
			dropped = 1'b1;	// Hold is over
		end
	end
	if (!dropped) begin
		$display("Timeout at %0t: busy did not rise and fall again", $time);
		errorCount++;
	end else if (cycles != expected) begin
		reportMismatch("busy cycles", expected, cycles);
	end
	@(posedge clock);
	#1;
endtask

task automatic runCompare(input opCode cmd, input logic [3:0] rs, input logic [3:0] rt);
	logic expT;
	if (cmd == opCmpEq) begin
		expT = (regModel[rs] == regModel[rt]);
	end else begin
		expT = ($signed(regModel[rs]) > $signed(regModel[rt]));	// Signed greater
	end
	issueOp(cmd, rs, rt, zeroReg, '0);
	clearOp();
	@(negedge clock);	// In EX1
	@(negedge clock);	// In EX2, flag already shown
	if (srT !== expT) begin
		reportMismatch("srT", expT, srT);
	end
	srTModel = expT;
	@(posedge clock);
	#1;
endtask

// Op squashed in EX2 after heldCycles of hold
task automatic flushOp(input opCode cmd, input logic [3:0] rs, input logic [3:0] rt,
		input logic [3:0] rn, input int heldCycles);
	issueOp(cmd, rs, rt, rn, '0);
	clearOp();
	@(posedge clock);
	#1;
	repeat (heldCycles) begin
		@(negedge clock);
		if (busy !== 1'b1) begin
			reportMismatch("busy", 1'b1, busy);
		end
		@(posedge clock);
		#1;
	end
	flush = 1'b1;
	@(negedge clock);	// Monitor also sees no writeback
	if (busy !== 1'b0) begin
		reportMismatch("busy", 1'b0, busy);
	end
	if (srT !== srTModel) begin
		reportMismatch("srT", srTModel, srT);
	end
	@(posedge clock);
	#1;
	flush = 1'b0;
	@(negedge clock);
	if (busy !== 1'b0) begin
		reportMismatch("busy", 1'b0, busy);
	end
	if (srT !== srTModel) begin
		reportMismatch("srT", srTModel, srT);
	end
	@(posedge clock);
	#1;
endtask

task automatic checkReset();
	@(negedge clock);
	if (busy !== 1'b0 || wbValid !== 1'b0 || srT !== 1'b0) begin
		$display("Outputs not cleared after reset at %0t", $time);
		errorCount++;
	end
	@(posedge clock);
	#1;
endtask

task automatic testAluOps();
	for (int r = 1; r < 7; r++) begin
		runOp(opMovImm, zeroReg, zeroReg, 4'(r), $random(seed));
	end
	drainWrites();
	runOp(opAdd, 1, 2, 7, '0);
	runOp(opSub, 3, 4, 8, '0);
	runOp(opAnd, 5, 6, 9, '0);
	runOp(opOr, 1, 3, 10, '0);
	runOp(opXor, 2, 4, 11, '0);
	runOp(opSub, 4, 3, 12, '0);
	drainWrites();
	runOp(opMovImm, zeroReg, zeroReg, zeroReg, $random(seed));	// Shows id 0
	drainWrites();
	runOp(opOr, zeroReg, zeroReg, 13, '0);	// R0 still reads zero
	drainWrites();
endtask

task automatic testForwarding();
	runOp(opAdd, 1, 2, 1, '0);
	runOp(opSub, 1, 3, 4, '0);	// Rs from the op in EX2
	runOp(opAnd, 4, 4, 5, '0);	// Both sources forwarded
	runOp(opXor, 2, 5, 6, '0);	// Rt forwarded
	runOp(opAdd, 4, 6, 2, '0);	// One from the file, one forwarded
	runOp(opMovImm, zeroReg, zeroReg, zeroReg, $random(seed));
	runOp(opAdd, zeroReg, zeroReg, 3, '0);	// R0 never forwarded
	drainWrites();
endtask

task automatic testCompares();
	runOp(opMovImm, zeroReg, zeroReg, 8, 32'h0000_0005);
	runOp(opMovImm, zeroReg, zeroReg, 9, 32'hffff_fff0);	// Negative
	runOp(opMovImm, zeroReg, zeroReg, 10, 32'h0000_0005);
	drainWrites();
	runCompare(opCmpEq, 8, 10);
	runCompare(opCmpEq, 8, 9);
	runCompare(opCmpGt, 8, 9);	// 5 above -16
	runCompare(opCmpGt, 9, 8);
	runCompare(opCmpGt, 8, 10);	// Equal is not greater
	runOp(opMovImm, zeroReg, zeroReg, 11, 32'h8000_0000);
	runCompare(opCmpGt, 8, 11);	// Forwarded most negative value
	drainWrites();
endtask

task automatic testMultiply();
	runOp(opMul, 1, 2, 11, '0);
	countBusy(mulBusyCycles);
	drainWrites();
	runOp(opMul, 11, 3, 12, '0);
	clearOp();
	@(posedge clock);
	#1;
	runOp(opAdd, 12, 11, 13, '0);	// Offered while busy
	drainWrites();
	runOp(opMul, 4, 4, 14, '0);
	runOp(opSub, 14, 2, 15, '0);	// Sits in EX1 through the hold
	drainWrites();
endtask

task automatic testSleep();
	issueOp(opSleep, zeroReg, zeroReg, zeroReg, '0);
	countBusy(sleepBusyCycles);
	drainWrites();
endtask

task automatic testFlush();
	flushOp(opAdd, 1, 2, 5, 0);
	runCompare(opCmpEq, 1, 1);	// T known high
	flushOp(opCmpEq, 8, 9, zeroReg, 0);	// Would clear T
	flushOp(opMul, 1, 2, 6, 1);	// Dropped in its second hold cycle
	runOp(opOr, 5, zeroReg, 7, '0);	// Read back the untouched targets
	runOp(opOr, 6, zeroReg, 8, '0);
	drainWrites();
endtask

/* tb/tbExPipeline.sv */
// Execute backend testbench
`timescale 1ns/1ps

module tbExPipeline import exPkg::*; ();

	localparam int dataWidth = 32;
	localparam int regCount = 16;
	localparam int waitLimit = 40;	// Cycles before any wait gives up
	localparam int mulBusyCycles = 3;	// Multiply hold length
	localparam int sleepBusyCycles = 15;	// Sleep hold length

	logic clock;
	logic rstN;
	logic opValid;
	opCode opCmd;
	logic [3:0] regIdRs;
	logic [3:0] regIdRt;
	logic [3:0] regIdRn;
	logic [dataWidth-1:0] regValImm;
	logic flush;
	logic busy;
	logic wbValid;
	logic [3:0] wbId;
	logic [dataWidth-1:0] wbValue;
	logic srT;

	logic [dataWidth-1:0] regModel [regCount];	// Reference register file
	logic srTModel;	// Last committed T
	logic [3:0] expIdQ [$];	// Writebacks still due, oldest first
	logic [dataWidth-1:0] expValQ [$];
	int errorCount;
	integer seed;

	exPipeline #(
		.dataWidth(dataWidth),
		.regCount(regCount)
	) dut (
		.clock(clock), .rstN(rstN),
		.opValid(opValid), .opCmd(opCmd),
		.regIdRs(regIdRs), .regIdRt(regIdRt), .regIdRn(regIdRn),
		.regValImm(regValImm), .flush(flush),
		.busy(busy), .wbValid(wbValid), .wbId(wbId),
		.wbValue(wbValue), .srT(srT)
	);

	`include "tbTasks.svh"

	always #10 clock = ~clock;	// 20 ns period

	// Writeback scoreboard, sampled mid cycle
	always @(negedge clock) begin : wbMonitor
		logic [3:0] expId;
		logic [dataWidth-1:0] expVal;
		if (rstN === 1'b1) begin
			if (wbValid === 1'b1) begin
				if (expIdQ.size() == 0) begin
					$display("Unexpected writeback at %0t to register %0d", $time, wbId);
					errorCount++;
				end else begin
					expId = expIdQ.pop_front();
					expVal = expValQ.pop_front();
					if (wbId !== expId) begin
						reportMismatch("wbId", expId, wbId);
					end
					if (wbValue !== expVal) begin
						reportMismatch("wbValue", expVal, wbValue);
					end
				end
			end else if (wbValid !== 1'b0) begin
				$display("Writeback valid is unknown at %0t", $time);
				errorCount++;
			end
		end
	end

	initial begin
		seed = 32'hd836_1aaf;
		errorCount = 0;
		clock = 1'b0;
		rstN = 1'b0;
		opValid = 1'b0;
		opCmd = opNop;
		regIdRs = '0;
		regIdRt = '0;
		regIdRn = '0;
		regValImm = '0;
		flush = 1'b0;
		srTModel = 1'b0;
		for (int i = 0; i < regCount; i++) begin
			regModel[i] = '0;	// Matches the cleared file
		end

		repeat (16) @(posedge clock);
		#1;
		rstN = 1'b1;

		checkReset();
		testAluOps();
		testForwarding();
		testCompares();
		testMultiply();
		testSleep();
		testFlush();
		drainWrites();

		$display("Errors: %0d", errorCount);
		if (errorCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+tb
source/exPkg.sv
source/regFile.sv
source/aluUnit.sv
source/mulUnit.sv
source/exStage1.sv
source/exStage2.sv
source/exPipeline.sv
tb/tbExPipeline.sv
